//--- hw/arb_defines.svh
/*
  Shared constants for the four-requester arbiter.
  Pulled in by the package and by any RTL that decodes mode codes
  or loops over requesters.
*/

`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

// Requester count and the index width that goes with it
`define ARB_NUM_REQ   4
`define ARB_IDX_W     2

// Arbitration mode field
`define ARB_MODE_W    3

// Mode codes, anything above RAND grants nobody
`define ARB_MODE_P0   3'd0
`define ARB_MODE_P1   3'd1
`define ARB_MODE_P2   3'd2
`define ARB_MODE_P3   3'd3
`define ARB_MODE_RR   3'd4
`define ARB_MODE_RAND 3'd5

// Pseudo-random generator depth
`define ARB_LFSR_W    3

`endif

//--- hw/arb_pkg.sv
/*
  Types shared by the arbiter RTL and its testbench.
  Import with arb_pkg::* in the module header.
*/

`include "arb_defines.svh"

package arb_pkg;

  // One request bit per requester
  typedef logic [`ARB_NUM_REQ-1:0] req_vec_t;

  // Grant, one-hot or all zero
  typedef logic [`ARB_NUM_REQ-1:0] gnt_vec_t;

  // Requester index: preferred requester, random pick, RR pointer
  typedef logic [`ARB_IDX_W-1:0]   req_idx_t;

  // Arbitration mode, see ARB_MODE_* codes
  typedef logic [`ARB_MODE_W-1:0]  arb_mode_t;

  // LFSR state, bit 0 is stage one
  typedef logic [`ARB_LFSR_W-1:0]  lfsr_state_t;

  // Input bundle sampled every clock
  typedef struct packed {
    req_vec_t  req;
    arb_mode_t mode;
  } arb_in_t;

endpackage

//--- hw/pn_seq_gen.sv
/*
  Three-stage LFSR giving the preferred requester for random mode.
  Free-running after reset, period of 7 states.
*/

`timescale 1ns/10ps

module pn_seq_gen import arb_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  output req_idx_t rand_idx
);

  lfsr_state_t state;  // {s3, s2, s1}
  logic        fb;

  // Feedback from stages one and three
  assign fb = state[0] ^ state[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= 3'b001;  // s1=1, s2=0, s3=0
    end else begin
      state <= {state[1], state[0], fb};  // Shift toward s3
    end
  end

  // Last two stages, s3 on top
  assign rand_idx = {state[2], state[1]};

endmodule

//--- hw/pref_priority_sel.sv
/*
  Fixed-priority picker with one preferred requester.
  The preferred requester wins if it asks, otherwise the lowest other
  requesting index does. Purely combinational.
*/

`timescale 1ns/10ps

module pref_priority_sel import arb_pkg::*; (
  input  req_vec_t req,
  input  req_idx_t pref,
  output gnt_vec_t gnt
);

  gnt_vec_t pref_mask;   // One-hot of the preferred index
  req_vec_t other_req;   // Everyone except the preferred requester
  gnt_vec_t low_gnt;     // Lowest bit of other_req
  logic     pref_hit;

  assign pref_mask = gnt_vec_t'(1) << pref;
  assign pref_hit  = req[pref];
  assign other_req = req & ~pref_mask;

  // Isolate lowest set bit, zero stays zero
  assign low_gnt = other_req & (~other_req + gnt_vec_t'(1));

  assign gnt = pref_hit ? pref_mask : low_gnt;

endmodule

//--- hw/rr_select.sv
/*
  Round-robin picker for four requesters.
  The last grant sets the pointer and the search starts one above it,
  wrapping, so the last winner is considered last. Combinational.
*/

`timescale 1ns/10ps

`include "arb_defines.svh"

module rr_select import arb_pkg::*; (
  input  req_vec_t req,
  input  gnt_vec_t last_gnt,
  output gnt_vec_t gnt
);

  req_idx_t ptr;

  // One-hot to index, no grant maps to 0
  assign ptr = {last_gnt[3] | last_gnt[2], last_gnt[3] | last_gnt[1]};

  always_comb begin
    req_idx_t idx;
    logic     found;

    gnt   = '0;
    found = 1'b0;
    // Offset NUM_REQ wraps back onto ptr itself
    for (int k = 1; k <= `ARB_NUM_REQ; k++) begin
      idx = ptr + req_idx_t'(k);
      if (!found && req[idx]) begin
        gnt[idx] = 1'b1;
        found    = 1'b1;
      end
    end
  end

endmodule

//--- hw/arbiter_core.sv
/*
  Arbiter core: runs the fixed, round-robin and random pickers in
  parallel and registers the one chosen by the mode field.
  Grant appears one clock after request and mode are sampled.
*/

`timescale 1ns/10ps

`include "arb_defines.svh"

module arbiter_core import arb_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  arb_in_t  arb_in,
  input  req_idx_t rand_idx,
  output gnt_vec_t gnt
);

  req_vec_t  req;
  arb_mode_t mode;
  req_idx_t  fix_pref;

  gnt_vec_t  fix_gnt;    // Modes 0..3
  gnt_vec_t  rr_gnt;     // Mode 4
  gnt_vec_t  rand_gnt;   // Mode 5
  gnt_vec_t  gnt_nxt;

  assign req  = arb_in.req;
  assign mode = arb_in.mode;

  // Low mode bits name the favoured requester in fixed modes
  assign fix_pref = mode[`ARB_IDX_W-1:0];

  pref_priority_sel fix_sel_inst (
    .req  (req),
    .pref (fix_pref),
    .gnt  (fix_gnt)
  );

  pref_priority_sel rand_sel_inst (
    .req  (req),
    .pref (rand_idx),
    .gnt  (rand_gnt)
  );

  // Pointer comes from our own registered grant
  rr_select rr_sel_inst (
    .req      (req),
    .last_gnt (gnt),
    .gnt      (rr_gnt)
  );

  always_comb begin
    case (mode)
      `ARB_MODE_P0,
      `ARB_MODE_P1,
      `ARB_MODE_P2,
      `ARB_MODE_P3:   gnt_nxt = fix_gnt;
      `ARB_MODE_RR:   gnt_nxt = rr_gnt;
      `ARB_MODE_RAND: gnt_nxt = rand_gnt;
      default:        gnt_nxt = '0;  // Modes 6, 7 grant nobody
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt <= '0;
    end else begin
      gnt <= gnt_nxt;
    end
  end

endmodule

//--- hw/arb_top.sv
/*
  Top level of the four-requester arbiter.
  Joins the LFSR for random mode to the arbiter core.
*/

`timescale 1ns/10ps

module arb_top import arb_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  arb_in_t  arb_in,
  output gnt_vec_t gnt
);

  req_idx_t rand_idx;  // Preferred requester in random mode

  pn_seq_gen pn_seq_gen_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_idx (rand_idx)
  );

  arbiter_core arbiter_core_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .arb_in   (arb_in),
    .rand_idx (rand_idx),
    .gnt      (gnt)
  );

endmodule

//--- verif/arb_assert.sv
/*
  Concurrent checks on the arbiter core grant register.
  Bound into every arbiter_core instance.
*/

`timescale 1ns/10ps

module arb_assert import arb_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input arb_in_t  arb_in,
  input gnt_vec_t gnt
);

  // Grant register still clear on the first edge out of reset
  a_reset_clear: assert property (@(posedge clk) $rose(rst_n) |-> (gnt == '0))
    else $error("Grant not zero on first edge after reset release");

  a_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
    else $error("Grant has more than one bit set: %b", gnt);

  // Winner must have been asking when its grant was computed
  a_was_requesting: assert property (
    @(posedge clk) disable iff (!rst_n)
    (gnt != '0) |-> ((gnt & $past(arb_in.req)) != '0))
    else $error("Grant %b given to a requester that was not asking", gnt);

endmodule

bind arbiter_core arb_assert arb_assert_inst (
  .clk    (clk),
  .rst_n  (rst_n),
  .arb_in (arb_in),
  .gnt    (gnt)
);

//--- verif/arb_tb.sv
/*
  Testbench for the four-requester arbiter.
  Keeps its own LFSR and grant model, compares gnt every cycle and
  runs directed sweeps followed by a long random mix.
*/

`timescale 1ns/10ps

`include "arb_defines.svh"

module arb_tb import arb_pkg::*;;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 5;
  localparam int FIX_CYCLES  = 4 * 16;
  localparam int RR_CYCLES   = 1 + 8 + 40;
  localparam int RAND_CYCLES = 28;
  localparam int IDLE_CYCLES = 16 + 8;   // Unused modes, then zero requests
  localparam int MIX_CYCLES  = 400;
  localparam int TEST_CYCLES = FIX_CYCLES + RR_CYCLES + RAND_CYCLES + IDLE_CYCLES
                               + MIX_CYCLES + 2;

  logic     clk;
  logic     rst_n;
  arb_in_t  arb_in;
  gnt_vec_t gnt;

  integer      seed = 32'hd967_7f63;
  int          errors = 0;
  int          checks = 0;
  logic        check_en = 1'b0;
  lfsr_state_t model_lfsr;   // {s3, s2, s1}
  gnt_vec_t    exp_gnt;      // Also the model's previous grant

  arb_top arb_top_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .arb_in (arb_in),
    .gnt    (gnt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic lfsr_state_t lfsr_step(input lfsr_state_t s);
    lfsr_state_t n;
    n[0] = s[0] ^ s[2];  // s1 gets s1 xor s3
    n[1] = s[0];
    n[2] = s[1];
    return n;
  endfunction

  function automatic req_idx_t lfsr_index(input lfsr_state_t s);
    return {s[2], s[1]};
  endfunction

  // Preferred requester first, then ascending order
  function automatic gnt_vec_t fixed_pick(input req_vec_t req, input int pref);
    gnt_vec_t pmask;
    gnt_vec_t m;
    gnt_vec_t g;
    pmask = gnt_vec_t'(1) << pref;
    g = '0;
    if ((req & pmask) != '0) begin
      g = pmask;
    end else begin
      for (int i = 0; i < `ARB_NUM_REQ; i++) begin
        m = gnt_vec_t'(1) << i;
        if (g == '0 && (req & m) != '0) g = m;
      end
    end
    return g;
  endfunction

  function automatic gnt_vec_t rotate_pick(input req_vec_t req, input gnt_vec_t prev);
    int       ptr;
    int       idx;
    gnt_vec_t m;
    gnt_vec_t g;
    ptr = 0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if ((prev & (gnt_vec_t'(1) << i)) != '0) ptr = i;
    end
    g = '0;
    for (int k = 1; k <= `ARB_NUM_REQ; k++) begin
      idx = (ptr + k) % `ARB_NUM_REQ;
      m = gnt_vec_t'(1) << idx;
      if (g == '0 && (req & m) != '0) g = m;
    end
    return g;
  endfunction

  function automatic gnt_vec_t expected_grant(input req_vec_t req, input arb_mode_t mode,
                                              input req_idx_t rnd, input gnt_vec_t prev);
    case (mode)
      `ARB_MODE_P0, `ARB_MODE_P1,
      `ARB_MODE_P2, `ARB_MODE_P3: return fixed_pick(req, int'(mode));
      `ARB_MODE_RR:               return rotate_pick(req, prev);
      `ARB_MODE_RAND:             return fixed_pick(req, int'(rnd));
      default:                    return '0;
    endcase
  endfunction

  // Reference model, same sampling point as the grant register
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_lfsr <= 3'b001;
      exp_gnt    <= '0;
    end else begin
      exp_gnt    <= expected_grant(arb_in.req, arb_in.mode, lfsr_index(model_lfsr), exp_gnt);
      model_lfsr <= lfsr_step(model_lfsr);
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Mismatch %s at %0t ns: got 0x%0h, expected 0x%0h", name, $time, got, want);
    end
  endtask

  always @(negedge clk) begin
    if (check_en) begin
      check_value("gnt", 32'(gnt), 32'(exp_gnt));
      check_value("rand_idx", 32'(arb_top_inst.rand_idx), 32'(lfsr_index(model_lfsr)));
    end
  end

  task automatic apply_inputs(input req_vec_t req, input arb_mode_t mode);
    @(negedge clk);
    arb_in.req  = req;
    arb_in.mode = mode;
  endtask

  task automatic reset_dut();
    rst_n  = 1'b0;
    arb_in = '0;
    @(posedge clk);
    check_en = 1'b1;  // gnt must read zero while reset is held
    repeat (RST_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic sweep_fixed_priority();
    for (int m = 0; m < 4; m++) begin
      for (int r = 0; r < 16; r++) apply_inputs(req_vec_t'(r), arb_mode_t'(m));
    end
  endtask

  task automatic rotate_round_robin();
    logic [31:0] rnd;
    apply_inputs('0, 3'd6);  // Clear the grant so the pointer starts at 0
    for (int i = 0; i < 8; i++) begin
      apply_inputs(4'hf, `ARB_MODE_RR);
      // Grant from the previous cycle, order 1, 2, 3, 0
      if (i > 0) check_value("gnt", 32'(gnt), 32'(gnt_vec_t'(1) << (i % 4)));
    end
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      apply_inputs(rnd[3:0], `ARB_MODE_RR);
    end
  endtask

  task automatic exercise_random_mode();
    logic [31:0] rnd;
    req_idx_t    seen[$];
    for (int i = 0; i < RAND_CYCLES; i++) begin
      rnd = $random(seed);
      apply_inputs(rnd[3:0], `ARB_MODE_RAND);
      seen.push_back(arb_top_inst.rand_idx);
      if (i >= 7) check_value("rand_idx", 32'(seen[i]), 32'(seen[i-7]));  // Period 7
    end
  endtask

  task automatic check_unused_modes();
    logic [31:0] rnd;
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      apply_inputs(rnd[3:0], (i % 2 == 0) ? 3'd6 : 3'd7);
    end
    for (int m = 0; m < 8; m++) apply_inputs('0, arb_mode_t'(m));
  endtask

  task automatic mixed_traffic();
    logic [31:0] rnd;
    for (int i = 0; i < MIX_CYCLES; i++) begin
      rnd = $random(seed);
      apply_inputs(rnd[3:0], rnd[6:4]);
    end
  endtask

  initial begin
    reset_dut();
    sweep_fixed_priority();
    rotate_round_robin();
    exercise_random_mode();
    check_unused_modes();
    mixed_traffic();
    apply_inputs('0, `ARB_MODE_P0);  // Drain the last grants through the compare
    apply_inputs('0, `ARB_MODE_P0);
    #(CLK_PERIOD/4);
    $display("Run finished with %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #((RST_CYCLES + TEST_CYCLES + 20) * CLK_PERIOD);
    $display("Timeout: the tests did not finish in the expected time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- arb_top.f
+incdir+hw
hw/arb_pkg.sv
hw/pn_seq_gen.sv
hw/pref_priority_sel.sv
hw/rr_select.sv
hw/arbiter_core.sv
hw/arb_top.sv
verif/arb_assert.sv
verif/arb_tb.sv

//--- Makefile
TOP   = arb_tb
FLIST = arb_top.f
LOG   = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	verilator --binary --assert -j 0 -f $(FLIST) --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
